/* instr_extract.sv */
// instruction extract: rotates and masks the buffered word into one macroinstruction and strobes it out
`timescale 1ns/1ps

module instr_extract (
   input  logic                                  clk,
   input  logic                                  reset,
   input  logic                                  deliver,
   input  macro_pkg::rot_sel_t                   rot_sel,
   input  logic                                  byte_mode,
   input  logic [macro_pkg::LC_WIDTH_DEFAULT-1:0] lc,
   input  macro_pkg::word_t                      buf_word,
   output logic                                  instr_valid,
   output macro_pkg::instr_out_t                 instr_out
);

   macro_pkg::word_t      half_rot;
   macro_pkg::word_t      byte_rot;
   macro_pkg::instr_t     instr;
   macro_pkg::instr_out_t fresh;   // result for the current location
   macro_pkg::instr_out_t held;    // last delivered instruction

   // byte 0 sits in bits 7:0, so rotating right brings the addressed unit down
   assign half_rot = rot_sel.in_left_half ? {buf_word[15:0], buf_word[31:16]} : buf_word;
   assign byte_rot = rot_sel.in_odd_quarter ? {half_rot[7:0], half_rot[31:8]} : half_rot;

   always_comb
   begin
      if (byte_mode == macro_pkg::MODE_HALF)
         instr = byte_rot[15:0];
      else
         instr = {8'h00, byte_rot[7:0]};
   end

   assign fresh.instr = instr;
   assign fresh.lc    = lc;

   // ==================================================
   // output stage
   // ==================================================

   always_ff @(posedge clk)
   begin
      if (reset)
         held <= '0;
      else if (deliver)
         held <= fresh;
   end

   assign instr_valid = deliver;
   assign instr_out   = deliver ? fresh : held;   // holds between strobes

   // each delivery needs a fresh consumer strobe, so pulses never touch
   a_single_pulse : assert property (@(posedge clk) disable iff (reset)
      instr_valid |=> !instr_valid);

endmodule

/* lc_control.sv */
// location counter control: fetch decision, stale word tracking, interrupt sampling, rotate selects
`timescale 1ns/1ps

module lc_control (
   input  logic                clk,
   input  logic                reset,
   input  logic                next_instr,
   input  logic                dest_lc,
   input  logic                byte_mode,
   input  logic                ext_int,
   input  logic                bus_int,
   input  logic [1:0]          lc,           // byte-in-word part of the location counter
   input  logic                crosses_word,
   input  logic                word_ready,
   output logic                lc_inc,
   output logic                lc_load,
   output logic                fetch_start,
   output logic                deliver,
   output macro_pkg::rot_sel_t rot_sel,
   output logic                sintr
);

   logic stale;         // buffered word does not belong to lc
   logic wrong_word;
   logic need_fetch;
   logic fetch_step;    // advance or jump in this cycle
   logic adv_deliver;   // buffer hit, instruction goes out next cycle
   logic wait_word;     // delivery waits for the memory word

   // ==================================================
   // fetch decision
   // ==================================================

   assign fetch_step  = next_instr | dest_lc;
   assign wrong_word  = stale | dest_lc;            // a jump always refetches
   assign need_fetch  = wrong_word | crosses_word;
   assign fetch_start = fetch_step & need_fetch;

   assign lc_load = dest_lc;
   assign lc_inc  = next_instr;

   assign deliver = adv_deliver | (word_ready & wait_word);

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         stale       <= 1'b1;   // nothing valid in the buffer yet
         wait_word   <= 1'b0;
         adv_deliver <= 1'b0;
         sintr       <= 1'b0;
      end
      else
      begin
         adv_deliver <= next_instr & ~need_fetch;

         if (dest_lc)
            stale <= 1'b1;
         else if (word_ready)
            stale <= 1'b0;

         if (fetch_start)
            wait_word <= 1'b1;
         else if (word_ready)
            wait_word <= 1'b0;

         if (fetch_step)
            sintr <= ext_int | bus_int;   // interrupt levels are sampled on the fetch step
      end
   end

   // ==================================================
   // rotate selects
   // ==================================================

   assign rot_sel.in_left_half   = lc[1];
   assign rot_sel.in_odd_quarter = lc[0] & (byte_mode == macro_pkg::MODE_BYTE);

   // the consumer waits for instr_valid before the next advance
   a_no_advance_while_pending : assert property (@(posedge clk) disable iff (reset)
      next_instr |-> !(adv_deliver || wait_word));

endmodule

/* lc_counter.sv */
// location counter: byte address of the current macroinstruction, loaded on a jump, stepped on advance
`timescale 1ns/1ps

module lc_counter #(
   parameter int lc_width = macro_pkg::LC_WIDTH_DEFAULT
) (
   input  logic                clk,
   input  logic                reset,
   input  logic                lc_load,
   input  logic [lc_width-1:0] new_lc,
   input  logic                lc_inc,
   input  logic                byte_mode,
   output logic [lc_width-1:0] lc,
   output logic                crosses_word
);

   logic [lc_width-1:0] lc_step;

   // one byte per advance in byte mode, one half-word otherwise
   assign lc_step = (byte_mode == macro_pkg::MODE_BYTE) ? lc_width'(1) : lc_width'(2);

   // ==================================================
   // word boundary test
   // ==================================================

   // the step leaves the word from the last byte, or from the upper half-word
   always_comb
   begin
      if (byte_mode == macro_pkg::MODE_BYTE)
         crosses_word = lc[1] & lc[0];
      else
         crosses_word = lc[1];
   end

   // ==================================================
   // counter register
   // ==================================================

   always_ff @(posedge clk)
   begin
      if (reset)
         lc <= '0;
      else if (lc_load)
         lc <= new_lc;   // a jump wins over an advance
      else if (lc_inc)
         lc <= lc + lc_step;
   end

   // a jump target holds whole instructions, so it is even outside byte mode
   a_half_aligned : assert property (@(posedge clk) disable iff (reset)
      (byte_mode == macro_pkg::MODE_HALF) |-> !lc[0]);

endmodule

/* macro_fetch_top.sv */
// macro fetch top: location counter, fetch control, word fetch and instruction extract
`timescale 1ns/1ps

module macro_fetch_top #(
   parameter int lc_width = macro_pkg::LC_WIDTH_DEFAULT
) (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  next_instr,
   input  logic                  dest_lc,
   input  logic [lc_width-1:0]   new_lc,
   input  logic                  byte_mode,
   input  logic                  ext_int,
   input  logic                  bus_int,
   input  logic                  mem_ack,
   input  macro_pkg::mem_rsp_t   mem_rsp,
   output logic                  mem_req_valid,
   output macro_pkg::mem_req_t   mem_req,
   output logic                  instr_valid,
   output macro_pkg::instr_out_t instr_out,
   output logic                  sintr
);

   logic [lc_width-1:0] lc;
   logic                crosses_word;
   logic                lc_inc;
   logic                lc_load;
   logic                fetch_start;
   logic                deliver;
   logic                word_ready;
   macro_pkg::rot_sel_t rot_sel;
   macro_pkg::word_t    buf_word;

   word_fetch #(.lc_width(lc_width)) i_word_fetch (
      .clk(clk), .reset(reset), .fetch_start(fetch_start), .lc(lc),
      .mem_ack(mem_ack), .mem_rsp(mem_rsp), .mem_req_valid(mem_req_valid),
      .mem_req(mem_req), .word_ready(word_ready), .buf_word(buf_word));

   lc_counter #(.lc_width(lc_width)) i_lc_counter (
      .clk(clk), .reset(reset), .lc_load(lc_load), .new_lc(new_lc), .lc_inc(lc_inc),
      .byte_mode(byte_mode), .lc(lc), .crosses_word(crosses_word));

   lc_control i_lc_control (
      .clk(clk), .reset(reset), .next_instr(next_instr), .dest_lc(dest_lc),
      .byte_mode(byte_mode), .ext_int(ext_int), .bus_int(bus_int), .lc(lc[1:0]),
      .crosses_word(crosses_word), .word_ready(word_ready), .lc_inc(lc_inc),
      .lc_load(lc_load), .fetch_start(fetch_start), .deliver(deliver),
      .rot_sel(rot_sel), .sintr(sintr));

   instr_extract i_instr_extract (
      .clk(clk), .reset(reset), .deliver(deliver), .rot_sel(rot_sel),
      .byte_mode(byte_mode), .lc(lc), .buf_word(buf_word),
      .instr_valid(instr_valid), .instr_out(instr_out));

endmodule

/* macro_pkg.sv */
// macro fetch types: memory handshake, instruction and rotate-select structs shared by the fetch unit
package macro_pkg;

   localparam int LC_WIDTH_DEFAULT = 26;   // byte location counter width in bits

   // byte_mode encodings
   localparam logic MODE_HALF = 1'b0;
   localparam logic MODE_BYTE = 1'b1;

   typedef logic [31:0] word_t;             // one memory word
   typedef logic [15:0] instr_t;            // upper byte is zero in byte mode

   typedef struct packed {
      logic [LC_WIDTH_DEFAULT-3:0] word_addr;   // lc without the byte-in-word bits
   } mem_req_t;

   typedef struct packed {
      word_t word;
   } mem_rsp_t;

   typedef struct packed {
      instr_t                      instr;
      logic [LC_WIDTH_DEFAULT-1:0] lc;      // byte location the instruction came from
   } instr_out_t;

   typedef struct packed {
      logic in_left_half;     // upper half-word, lc bit 1
      logic in_odd_quarter;   // odd byte of the half-word, byte mode only
   } rot_sel_t;

endpackage

/* project.f */
macro_pkg.sv
word_fetch.sv
lc_counter.sv
lc_control.sv
instr_extract.sv
macro_fetch_top.sv
tb_checker.sv
tb_macro_fetch.sv

/* run.sh */
#!/bin/sh
# build the testbench with Verilator, run it, then scan the log for the fail message
verilator --binary --timing --assert -f project.f --top-module tb_macro_fetch \
   -o sim_macro_fetch > build.log 2>&1 \
   || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/sim_macro_fetch > sim.log 2>&1 \
   || { cat sim.log; echo "simulation aborted"; exit 1; }
cat sim.log
grep -q "TEST FAILED" sim.log && exit 1 || exit 0

/* tb_checker.sv */
// fetch checker: follows the strobes, keeps the expected location and compares the DUT outputs
`timescale 1ns/1ps

module tb_checker #(
   parameter int lc_width = macro_pkg::LC_WIDTH_DEFAULT
) (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  next_instr,
   input  logic                  dest_lc,
   input  logic [lc_width-1:0]   new_lc,
   input  logic                  byte_mode,
   input  logic                  ext_int,
   input  logic                  bus_int,
   input  logic                  mem_ack,
   input  macro_pkg::mem_rsp_t   mem_rsp,
   input  logic                  mem_req_valid,
   input  macro_pkg::mem_req_t   mem_req,
   input  logic                  instr_valid,
   input  macro_pkg::instr_out_t instr_out,
   input  logic                  sintr,
   output int                    strobe_errors,
   output int                    data_errors
);

   logic [lc_width-1:0] exp_lc;
   logic [lc_width-1:0] next_lc;
   macro_pkg::word_t    exp_word;   // last word the memory handed back
   logic                buf_ok;     // exp_word holds the word of exp_lc
   logic                req_due;    // mem_req_valid expected at this sample
   logic                dlv_due;    // instr_valid expected at this sample
   logic                exp_sintr;

   // byte 0 of a word sits in bits 7:0, half-word 0 in bits 15:0
   function automatic macro_pkg::instr_t expected_instr(input macro_pkg::word_t w,
                                                       input logic [1:0] loc,
                                                       input logic bmode);
      logic [15:0] half;
      logic [7:0]  one_byte;
      half     = loc[1] ? w[31:16] : w[15:0];
      one_byte = loc[0] ? half[15:8] : half[7:0];
      return bmode ? {8'h00, one_byte} : half;
   endfunction

   task automatic report_mismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] exp, input bit is_strobe);
      $display("Error at %t: %s is %h, expected %h", $time, name, got, exp);
      if (is_strobe)
         strobe_errors++;
      else
         data_errors++;
   endtask

   // ==================================================
   // compare at the falling edge, where every signal is settled
   // ==================================================

   always @(negedge clk)
   begin
      if (reset)
      begin
         exp_lc        = '0;
         buf_ok        = 1'b0;
         req_due       = 1'b0;
         dlv_due       = 1'b0;
         exp_sintr     = 1'b0;
         strobe_errors = 0;
         data_errors   = 0;
      end
      else
      begin
         if (mem_req_valid !== req_due)
            report_mismatch("mem_req_valid", 32'(mem_req_valid), 32'(req_due), 1'b1);
         if (mem_req_valid && mem_req.word_addr !== exp_lc[lc_width-1:2])
            report_mismatch("mem_req.word_addr", 32'(mem_req.word_addr),
                            32'(exp_lc[lc_width-1:2]), 1'b0);
         if (instr_valid !== dlv_due)
            report_mismatch("instr_valid", 32'(instr_valid), 32'(dlv_due), 1'b1);
         if (instr_valid)
         begin
            if (instr_out.instr !== expected_instr(exp_word, exp_lc[1:0], byte_mode))
               report_mismatch("instr_out.instr", 32'(instr_out.instr),
                               32'(expected_instr(exp_word, exp_lc[1:0], byte_mode)), 1'b0);
            if (instr_out.lc !== exp_lc)
               report_mismatch("instr_out.lc", 32'(instr_out.lc), 32'(exp_lc), 1'b0);
         end
         if (sintr !== exp_sintr)
            report_mismatch("sintr", 32'(sintr), 32'(exp_sintr), 1'b0);

         req_due = 1'b0;
         dlv_due = 1'b0;
         if (dest_lc)
         begin
            exp_lc  = new_lc;   // a jump always reads memory
            buf_ok  = 1'b0;
            req_due = 1'b1;
         end
         else if (next_instr)
         begin
            next_lc = exp_lc + (byte_mode ? lc_width'(1) : lc_width'(2));
            if (!buf_ok || next_lc[lc_width-1:2] != exp_lc[lc_width-1:2])
            begin
               buf_ok  = 1'b0;
               req_due = 1'b1;
            end
            else
               dlv_due = 1'b1;   // same word, straight from the buffer
            exp_lc = next_lc;
         end
         if (dest_lc || next_instr)
            exp_sintr = ext_int | bus_int;
         if (mem_ack)
         begin
            exp_word = mem_rsp.word;
            buf_ok   = 1'b1;
            dlv_due  = 1'b1;
         end
      end
   end

endmodule

/* tb_macro_fetch.sv */
// testbench for the macro fetch unit with clock, reset, memory model and random advances and jumps
`timescale 1ns/1ps

module tb_macro_fetch;

   localparam int lc_width    = macro_pkg::LC_WIDTH_DEFAULT;
   localparam int num_ops     = 300;
   localparam int watchdog_ns = (num_ops * 10 + 40) * 20;   // an op takes at most about 8 cycles

   logic                  clk = 1'b0;
   logic                  reset;
   logic                  next_instr;
   logic                  dest_lc;
   logic [lc_width-1:0]   new_lc;
   logic                  byte_mode;
   logic                  ext_int;
   logic                  bus_int;
   logic                  mem_ack;
   macro_pkg::mem_rsp_t   mem_rsp;
   logic                  mem_req_valid;
   macro_pkg::mem_req_t   mem_req;
   logic                  instr_valid;
   macro_pkg::instr_out_t instr_out;
   logic                  sintr;
   int                    strobe_errors;
   int                    data_errors;
   logic [31:0]           lfsr = 32'h3b9f_3360;

   always #10 clk = ~clk;

   // 32-bit Fibonacci LFSR with taps 32 22 2 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic take_bits(input int n, output logic [31:0] bits);
      bits = '0;
      for (int i = 0; i < n; i++)
      begin
         lfsr = lfsr_next(lfsr);
         bits = {bits[30:0], lfsr[0]};
      end
   endtask

   // memory contents where every address bit feeds the word
   function automatic macro_pkg::word_t scramble_word(input logic [23:0] addr);
      macro_pkg::word_t w;
      w = {8'h00, addr} * 32'h9e37_79b1;
      return w ^ {w[12:0], w[31:13]} ^ 32'h5a5a_0f0f;
   endfunction

   macro_fetch_top #(.lc_width(lc_width)) i_macro_fetch_top (.*);

   tb_checker #(.lc_width(lc_width)) i_checker (.*);

   // ==================================================
   // stimulus
   // ==================================================

   initial
   begin
      logic [31:0] bits;
      logic        mode;
      $timeformat(-9, 0, " ns", 0);
      reset      = 1'b1;
      next_instr = 1'b0;
      dest_lc    = 1'b0;
      new_lc     = '0;
      byte_mode  = macro_pkg::MODE_HALF;
      ext_int    = 1'b0;
      bus_int    = 1'b0;
      repeat (4) @(posedge clk);
      #1 reset = 1'b0;
      repeat (6) @(posedge clk);   // the unit must stay quiet through this idle stretch
      for (int op = 0; op < num_ops; op++)
      begin
         #1;
         take_bits(3, bits);
         if (op == 0 || bits[2:0] == 3'd0)
         begin
            take_bits(1, bits);
            mode = bits[0] | instr_out.lc[0];   // stay in byte mode while sitting on an odd byte
            take_bits(lc_width, bits);
            new_lc    = {bits[lc_width-1:1], bits[0] & mode};
            byte_mode = mode;
            dest_lc   = 1'b1;
         end
         else
            next_instr = 1'b1;
         take_bits(2, bits);
         ext_int = bits[1];
         bus_int = bits[0];
         @(posedge clk);
         #1;
         dest_lc    = 1'b0;
         next_instr = 1'b0;
         take_bits(2, bits);
         ext_int = bits[1];   // sintr must ignore these until the next strobe
         bus_int = bits[0];
         @(negedge clk);
         while (!instr_valid)
            @(negedge clk);
         @(posedge clk);
      end
      repeat (4) @(posedge clk);
      $display("errors: %0d strobe, %0d data", strobe_errors, data_errors);
      if (strobe_errors == 0 && data_errors == 0)
         $display("TEST PASSED");
      else
         $display("TEST FAILED");
      $finish;
   end

   // memory model that gives one answer per request after 1 to 4 cycles
   initial
   begin
      logic [31:0] delay;
      logic [23:0] addr;
      mem_ack = 1'b0;
      mem_rsp = '0;
      forever
      begin
         @(negedge clk);
         if (!reset && mem_req_valid)
         begin
            addr = mem_req.word_addr;
            take_bits(2, delay);
            repeat (delay[1:0]) @(posedge clk);
            @(posedge clk);
            #1;
            mem_ack      = 1'b1;
            mem_rsp.word = scramble_word(addr);
            @(posedge clk);
            #1;
            mem_ack      = 1'b0;
            mem_rsp.word = ~mem_rsp.word;   // the data bus carries junk outside the ack cycle
         end
      end
   end

   initial
   begin
      #(watchdog_ns);
      $display("timeout: no instruction delivered in time, %0d strobe and %0d data errors so far",
               strobe_errors, data_errors);
      $display("TEST FAILED");
      $finish;
   end

endmodule

/* word_fetch.sv */
// word fetch: issues one memory word read per fetch request and captures the returned word
`timescale 1ns/1ps

module word_fetch #(
   parameter int lc_width = macro_pkg::LC_WIDTH_DEFAULT
) (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 fetch_start,
   input  logic [lc_width-1:0]  lc,
   input  logic                 mem_ack,
   input  macro_pkg::mem_rsp_t  mem_rsp,
   output logic                 mem_req_valid,
   output macro_pkg::mem_req_t  mem_req,
   output logic                 word_ready,
   output macro_pkg::word_t     buf_word
);

   logic outstanding;   // one read in flight
   logic accept_rsp;

   // ==================================================
   // request side
   // ==================================================

   // the counter already holds the new location when the request goes out,
   // and it stays put until the word has been delivered
   assign mem_req.word_addr = lc[lc_width-1:2];

   assign accept_rsp = mem_ack & outstanding;   // a stray ack is dropped here

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         mem_req_valid <= 1'b0;
         outstanding   <= 1'b0;
         word_ready    <= 1'b0;
      end
      else
      begin
         mem_req_valid <= fetch_start;   // one-cycle strobe
         word_ready    <= accept_rsp;
         if (fetch_start)
            outstanding <= 1'b1;
         else if (accept_rsp)
            outstanding <= 1'b0;
      end
   end

   // ==================================================
   // instruction buffer
   // ==================================================

   always_ff @(posedge clk)
   begin
      if (accept_rsp)
         buf_word <= mem_rsp.word;
   end

   // the controller must not ask for a new word before the last one came back
   a_no_fetch_while_busy : assert property (@(posedge clk) disable iff (reset)
      fetch_start |-> !outstanding);

   // memory answers only what was asked
   a_no_stray_ack : assert property (@(posedge clk) disable iff (reset)
      mem_ack |-> outstanding);

endmodule
